/* design/calc_pkg.sv */
`default_nettype none

package calc_pkg;

    // Width of operands, results and the display register
    parameter int DATA_W = 16;

    // Operator keys arrive one-hot from the keypad
    typedef enum logic [2:0] {
        OP_ADD = 3'b001,
        OP_SUB = 3'b010,
        OP_MUL = 3'b100
    } op_t;

    // Operand pair handed to either arithmetic unit
    typedef struct packed {
        logic [DATA_W-1:0] a;                   // Left operand
        logic [DATA_W-1:0] b;                   // Right operand
    } operands_t;

    // Request to the add/subtract unit
    typedef struct packed {
        logic start;                            // One-cycle launch
        logic sub;                              // 1 selects a - b
    } arith_ctl_t;

endpackage

`default_nettype wire

/* design/add_sub_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module add_sub_unit (
    input  logic                        clk,
    input  logic                        nRST,
    input  calc_pkg::arith_ctl_t        ctl,
    input  calc_pkg::operands_t         operands,
    output logic [calc_pkg::DATA_W-1:0] result,
    output logic                        finish
);

    logic [calc_pkg::DATA_W-1:0] sum;           // Wraps modulo 2^DATA_W

    always_comb begin
        if (ctl.sub) begin
            sum = operands.a - operands.b;
        end else begin
            sum = operands.a + operands.b;
        end
    end

    // Result register, loaded only on a request
    always_ff @(posedge clk) begin
        if (ctl.start) begin
            result <= sum;
        end
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            finish <= 1'b0;
        end else begin
            finish <= ctl.start;                // Done one cycle after start
        end
    end

    // The controller waits for finish before the next start, so finish
    // can never stay up for two cycles in a row
    assert property (@(posedge clk) disable iff (!nRST)
        finish |=> !finish)
        else $error("add_sub_unit: finish held for more than one cycle");

endmodule

`default_nettype wire

/* design/mult_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module mult_unit #(
    parameter int MULT_STEP = 1                 // Multiplier bits retired per cycle
) (
    input  logic                        clk,
    input  logic                        nRST,
    input  logic                        start,
    input  calc_pkg::operands_t         operands,
    output logic [calc_pkg::DATA_W-1:0] product,
    output logic                        finish
);

    localparam int W     = calc_pkg::DATA_W;
    localparam int STEPS = W / MULT_STEP;       // Cycles from start to finish
    localparam int CNT_W = $clog2(STEPS + 1);

    if (W % MULT_STEP != 0) begin : g_step_check
        $error("mult_unit: MULT_STEP must divide DATA_W");
    end

    logic [W-1:0]     mcand;                    // Shifts left by MULT_STEP
    logic [W-1:0]     mplier;                   // Shifts right by MULT_STEP
    logic [W-1:0]     acc;
    logic [CNT_W-1:0] count;                    // Steps still to run
    logic             busy;

    // Sum of the partial products for the low MULT_STEP multiplier bits
    function automatic logic [W-1:0] partial(input logic [W-1:0] mc,
                                             input logic [W-1:0] mp);
        logic [W-1:0] sum;
        sum = '0;
        for (int i = 0; i < MULT_STEP; i++) begin
            if (mp[i]) begin
                sum = sum + (mc << i);
            end
        end
        return sum;
    endfunction

    // First step runs on the start edge itself
    always_ff @(posedge clk) begin
        if (start) begin
            acc    <= partial(operands.a, operands.b);
            mcand  <= operands.a << MULT_STEP;
            mplier <= operands.b >> MULT_STEP;
        end else if (busy) begin
            acc    <= acc + partial(mcand, mplier);
            mcand  <= mcand << MULT_STEP;
            mplier <= mplier >> MULT_STEP;
        end
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            busy   <= 1'b0;
            count  <= '0;
            finish <= 1'b0;
        end else begin
            finish <= 1'b0;
            if (start) begin
                busy  <= 1'b1;
                count <= CNT_W'(STEPS - 1);
            end else if (busy) begin
                count <= count - 1'b1;
                if (count == CNT_W'(1)) begin
                    busy   <= 1'b0;           // Last step in this cycle
                    finish <= 1'b1;
                end
            end
        end
    end

    assign product = acc;                       // Low W bits only

    assert property (@(posedge clk) disable iff (!nRST)
        start |-> !busy)
        else $error("mult_unit: start while a multiplication is running");

endmodule

`default_nettype wire

/* design/calc_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module calc_ctrl (
    input  logic                        clk,
    input  logic                        nRST,
    input  logic [3:0]                  key_digit,
    input  logic                        key_valid,
    input  calc_pkg::op_t               op_code,
    input  logic                        op_valid,
    input  logic                        equal,
    output logic                        ready,
    output logic                        complete,
    output logic [calc_pkg::DATA_W-1:0] display,
    output calc_pkg::arith_ctl_t        add_ctl,
    output calc_pkg::operands_t         add_operands,
    input  logic [calc_pkg::DATA_W-1:0] add_result,
    input  logic                        add_finish,
    output logic                        mul_start,
    output calc_pkg::operands_t         mul_operands,
    input  logic [calc_pkg::DATA_W-1:0] mul_product,
    input  logic                        mul_finish
);

    localparam int W = calc_pkg::DATA_W;

    typedef enum logic [2:0] {
        S_ENTER_A,                              // Building the first operand
        S_SCALE,                                // Operand times ten on the multiplier
        S_ADD_DIGIT,                            // Adding the new digit
        S_ENTER_B,                              // Building the second operand
        S_COMPUTE,                              // Waiting on the final result
        S_SHOW                                  // Result cycle, keys still taken
    } state_t;

    state_t        state;
    logic [W-1:0]  op_a;
    logic [W-1:0]  op_b;
    logic          build_b;                     // Digits go to op_b when set
    calc_pkg::op_t op_q;                        // Latched operator
    logic [3:0]    digit_q;

    logic         digit_accept;
    logic         op_accept;
    logic         eq_accept;
    logic         scale_done;
    logic         add_done;
    logic         calc_done;
    logic         is_mul;
    logic [W-1:0] cur_operand;

    assign ready    = (state == S_ENTER_A) || (state == S_ENTER_B) || (state == S_SHOW);
    assign complete = (state == S_SHOW);

    // Digit beats operator beats equals if strobes coincide
    assign digit_accept = ready && key_valid;
    assign op_accept    = ready && op_valid && !key_valid && !build_b;
    assign eq_accept    = ready && equal && !key_valid && !op_valid && build_b;

    assign is_mul      = (op_q == calc_pkg::OP_MUL);
    assign scale_done  = (state == S_SCALE) && mul_finish;
    assign add_done    = (state == S_ADD_DIGIT) && add_finish;
    assign calc_done   = (state == S_COMPUTE) && (is_mul ? mul_finish : add_finish);
    assign cur_operand = build_b ? op_b : op_a;

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            state     <= S_ENTER_A;
            op_a      <= '0;
            op_b      <= '0;
            build_b   <= 1'b0;
            op_q      <= calc_pkg::OP_ADD;
            display   <= '0;
            mul_start <= 1'b0;
            add_ctl   <= '0;
        end else begin
            mul_start     <= 1'b0;              // Starts are single-cycle
            add_ctl.start <= 1'b0;
            case (state)
                S_ENTER_A, S_ENTER_B, S_SHOW: begin
                    if (digit_accept) begin
                        mul_start <= 1'b1;
                        state     <= S_SCALE;
                    end else if (op_accept) begin
                        op_q    <= op_code;
                        build_b <= 1'b1;
                        state   <= S_ENTER_B;
                    end else if (eq_accept) begin
                        if (is_mul) begin
                            mul_start <= 1'b1;
                        end else begin
                            add_ctl <= '{start: 1'b1, sub: (op_q == calc_pkg::OP_SUB)};
                        end
                        state <= S_COMPUTE;
                    end else if (state == S_SHOW) begin
                        state <= S_ENTER_A;
                    end
                end
                S_SCALE: begin
                    if (scale_done) begin
                        add_ctl <= '{start: 1'b1, sub: 1'b0};
                        state   <= S_ADD_DIGIT;
                    end
                end
                S_ADD_DIGIT: begin
                    if (add_done) begin
                        if (build_b) begin
                            op_b  <= add_result;
                            state <= S_ENTER_B;
                        end else begin
                            op_a  <= add_result;
                            state <= S_ENTER_A;
                        end
                    end
                end
                S_COMPUTE: begin
                    if (calc_done) begin
                        display <= is_mul ? mul_product : add_result;
                        op_a    <= '0;          // Next entry starts from zero
                        op_b    <= '0;
                        build_b <= 1'b0;
                        state   <= S_SHOW;
                    end
                end
                default: state <= S_ENTER_A;
            endcase
        end
    end

    // Operand payloads, valid on the cycle their start is high
    always_ff @(posedge clk) begin
        if (digit_accept) begin
            digit_q      <= key_digit;
            mul_operands <= '{a: cur_operand, b: W'(10)};
        end else if (eq_accept) begin
            mul_operands <= '{a: op_a, b: op_b};
        end
        if (scale_done) begin
            add_operands <= '{a: mul_product, b: {{(W - 4){1'b0}}, digit_q}};
        end else if (eq_accept) begin
            add_operands <= '{a: op_a, b: op_b};
        end
    end

    assert property (@(posedge clk) disable iff (!nRST)
        op_accept |-> $onehot(op_code))
        else $error("calc_ctrl: operator key is not one-hot");

endmodule

`default_nettype wire

/* design/calc_top.sv */
`timescale 1ns/1ps
`default_nettype none

module calc_top #(
    parameter int MULT_STEP = 1                 // Passed to the multiplier
) (
    input  logic                        clk,
    input  logic                        nRST,
    input  logic [3:0]                  key_digit,
    input  logic                        key_valid,
    input  calc_pkg::op_t               op_code,
    input  logic                        op_valid,
    input  logic                        equal,
    output logic                        ready,
    output logic                        complete,
    output logic [calc_pkg::DATA_W-1:0] display
);

    calc_pkg::arith_ctl_t        add_ctl;
    calc_pkg::operands_t         add_operands;
    logic [calc_pkg::DATA_W-1:0] add_result;
    logic                        add_finish;
    logic                        mul_start;
    calc_pkg::operands_t         mul_operands;
    logic [calc_pkg::DATA_W-1:0] mul_product;
    logic                        mul_finish;

    calc_ctrl ctrl0 (
        .clk          (clk),
        .nRST         (nRST),
        .key_digit    (key_digit),
        .key_valid    (key_valid),
        .op_code      (op_code),
        .op_valid     (op_valid),
        .equal        (equal),
        .ready        (ready),
        .complete     (complete),
        .display      (display),
        .add_ctl      (add_ctl),
        .add_operands (add_operands),
        .add_result   (add_result),
        .add_finish   (add_finish),
        .mul_start    (mul_start),
        .mul_operands (mul_operands),
        .mul_product  (mul_product),
        .mul_finish   (mul_finish)
    );

    add_sub_unit add0 (
        .clk      (clk),
        .nRST     (nRST),
        .ctl      (add_ctl),
        .operands (add_operands),
        .result   (add_result),
        .finish   (add_finish)
    );

    mult_unit #(
        .MULT_STEP (MULT_STEP)
    ) mul0 (
        .clk      (clk),
        .nRST     (nRST),
        .start    (mul_start),
        .operands (mul_operands),
        .product  (mul_product),
        .finish   (mul_finish)
    );

endmodule

`default_nettype wire

/* verification/calc_ref.svh */
`ifndef CALC_REF_SVH
`define CALC_REF_SVH

typedef logic [calc_pkg::DATA_W-1:0] word_t;    // Value modulo 2^DATA_W

// Decimal digit at key position pos; position 0 is the first key pressed
function automatic int unsigned key_at(input int unsigned value, input int count,
                                       input int pos);
    int unsigned scale;
    scale = 1;
    for (int i = 0; i < count - 1 - pos; i++) begin
        scale = scale * 10;
    end
    return (value / scale) % 10;
endfunction

// Operand as the keypad builds it, one digit at a time
function automatic word_t fold_digits(input int unsigned value, input int count);
    word_t acc;
    acc = '0;
    for (int i = 0; i < count; i++) begin
        acc = acc * word_t'(10) + word_t'(key_at(value, count, i));
    end
    return acc;
endfunction

function automatic word_t apply_op(input calc_pkg::op_t op, input word_t a, input word_t b);
    case (op)
        calc_pkg::OP_SUB: return a - b;             // Wraps below zero
        calc_pkg::OP_MUL: return a * b;             // Low bits of the product
        default:          return a + b;
    endcase
endfunction

`endif

/* verification/calc_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module calc_tb;

    localparam int W              = calc_pkg::DATA_W;
    localparam int NUM_CALCS      = 23;
    // Operands reach 5 digits each, hence the factor 2
    localparam int TIMEOUT_CYCLES = 2 * NUM_CALCS * (6 * (W + 4) + W + 10) + 500;
    localparam int KEY_DIGIT      = 0;
    localparam int KEY_OP         = 1;
    localparam int KEY_EQUAL      = 2;

    `include "calc_ref.svh"

    logic          clk;
    logic          nRST;
    logic [3:0]    key_digit;
    logic          key_valid;
    calc_pkg::op_t op_code;
    logic          op_valid;
    logic          equal;
    logic          ready;
    logic          complete;
    logic [W-1:0]  display;

    word_t expected_q[$];                           // One entry per pending equals
    word_t exp_val;
    word_t shown         = '0;                      // Last value seen on complete
    logic  complete_prev = 1'b0;
    int    pass_count     = 0;
    int    fail_count     = 0;
    int    complete_count = 0;
    int    equals_count   = 0;
    int    cycle_count    = 0;
    int    errors_before;
    int    na;
    int    nb;

    calc_top dut0 (
        .clk       (clk),
        .nRST      (nRST),
        .key_digit (key_digit),
        .key_valid (key_valid),
        .op_code   (op_code),
        .op_valid  (op_valid),
        .equal     (equal),
        .ready     (ready),
        .complete  (complete),
        .display   (display)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic report_mismatch(input string name, input word_t exp, input word_t got);
        fail_count++;
        $display("[ERROR] %0t %s expected %0d got %0d", $time, name, exp, got);
    endtask

    // One-cycle key strobe, held back until the core is ready
    task automatic press_key(input int kind, input logic [3:0] d, input calc_pkg::op_t op);
        while (!ready) begin
            @(posedge clk);
            #1;
        end
        key_digit = d;
        op_code   = op;
        key_valid = (kind == KEY_DIGIT);
        op_valid  = (kind == KEY_OP);
        equal     = (kind == KEY_EQUAL);
        if (kind == KEY_EQUAL) begin
            equals_count++;
        end
        @(posedge clk);
        #1;
        key_valid = 1'b0;
        op_valid  = 1'b0;
        equal     = 1'b0;
    endtask

    // Digit strobe while the core is busy scaling
    task automatic send_stray_digit();
        if (ready) begin
            fail_count++;
            $display("ready still high the cycle after a digit key at %0t", $time);
        end
        key_digit = 4'd9;
        key_valid = 1'b1;
        @(posedge clk);
        #1;
        key_valid = 1'b0;
    endtask

    task automatic enter_operand(input int unsigned value, input int count, input bit stray);
        for (int i = 0; i < count; i++) begin
            press_key(KEY_DIGIT, 4'(key_at(value, count, i)), calc_pkg::OP_ADD);
            if (stray && i == 0) begin
                send_stray_digit();
            end
        end
    endtask

    task automatic run_calc(input int unsigned a, input int ca, input calc_pkg::op_t op,
                            input int unsigned b, input int cb, input bit stray);
        int target;
        expected_q.push_back(apply_op(op, fold_digits(a, ca), fold_digits(b, cb)));
        enter_operand(a, ca, stray);
        press_key(KEY_OP, 4'd0, op);
        enter_operand(b, cb, 1'b0);
        press_key(KEY_EQUAL, 4'd0, op);
        target = complete_count + 1;
        while (complete_count < target) begin    // Timeout process bounds this
            @(posedge clk);
            #1;
        end
    endtask

    task automatic end_test(input string name, input int errors_at_start);
        $display("test %s finished, %0d errors", name, fail_count - errors_at_start);
    endtask

    // Results are compared mid-cycle, away from the clock edge
    always @(negedge clk) begin
        if (nRST && complete) begin
            complete_count++;
            if (complete_prev) begin
                fail_count++;
                $display("complete stayed high for more than one cycle at %0t", $time);
            end
            if (expected_q.size() == 0) begin
                fail_count++;
                $display("complete pulsed with no equals key pending at %0t", $time);
            end else begin
                exp_val = expected_q.pop_front();
                if (display !== exp_val) begin
                    report_mismatch("display", exp_val, display);
                end else begin
                    pass_count++;
                end
            end
            shown = display;
        end else if (nRST && display !== shown) begin
            report_mismatch("display", shown, display);   // Must hold between results
            shown = display;
        end
        complete_prev = nRST && complete;
    end

    initial begin
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Run timed out waiting on ready or complete after %0d cycles", cycle_count);
        $display("TESTS FAILED");
        $finish;
    end

    initial begin
        nRST      = 1'b0;
        key_digit = 4'd0;
        key_valid = 1'b0;
        op_code   = calc_pkg::OP_ADD;
        op_valid  = 1'b0;
        equal     = 1'b0;
        void'($urandom(32'h6592_a2b5));
        repeat (10) @(posedge clk);
        #1;
        nRST = 1'b1;
        @(posedge clk);
        #1;

        errors_before = fail_count;
        if (ready !== 1'b1) begin
            report_mismatch("ready", W'(1), W'(ready));
        end
        if (complete !== 1'b0) begin
            report_mismatch("complete", W'(0), W'(complete));
        end
        if (display !== '0) begin
            report_mismatch("display", '0, display);
        end
        end_test("reset", errors_before);

        errors_before = fail_count;
        for (int i = 0; i < 8; i++) begin
            na = 1 + $urandom % 4;
            nb = 1 + $urandom % 4;
            run_calc($urandom % 10000, na, calc_pkg::OP_ADD, $urandom % 10000, nb, 1'b0);
        end
        end_test("addition", errors_before);

        errors_before = fail_count;
        run_calc(12, 2, calc_pkg::OP_SUB, 345, 3, 1'b0);      // Wraps below zero
        run_calc(0, 1, calc_pkg::OP_SUB, 7, 1, 1'b0);
        run_calc(500, 3, calc_pkg::OP_SUB, 0, 1, 1'b0);
        run_calc($urandom % 1000, 3, calc_pkg::OP_SUB, $urandom % 1000, 3, 1'b0);
        run_calc($urandom % 100, 2, calc_pkg::OP_SUB, $urandom % 10000, 4, 1'b0);
        end_test("subtraction", errors_before);

        errors_before = fail_count;
        run_calc(300, 3, calc_pkg::OP_MUL, 300, 3, 1'b0);
        run_calc(99999, 5, calc_pkg::OP_MUL, 3, 1, 1'b0);     // Folds past 2^16
        run_calc(65536, 5, calc_pkg::OP_MUL, 7, 1, 1'b0);
        run_calc(12345, 5, calc_pkg::OP_MUL, 54321, 5, 1'b0);
        run_calc($urandom % 100000, 5, calc_pkg::OP_MUL, $urandom % 100000, 5, 1'b0);
        run_calc($urandom % 100000, 5, calc_pkg::OP_MUL, $urandom % 100000, 5, 1'b0);
        end_test("multiplication", errors_before);

        errors_before = fail_count;
        run_calc(42, 2, calc_pkg::OP_ADD, 8, 1, 1'b1);
        run_calc(7, 1, calc_pkg::OP_MUL, 6, 1, 1'b1);
        run_calc(5, 1, calc_pkg::OP_ADD, 3, 1, 1'b0);         // Fresh operands after a result
        end_test("ignored keys", errors_before);

        errors_before = fail_count;
        repeat (30) @(posedge clk);                          // Display must hold while idle
        #1;
        run_calc(1, 1, calc_pkg::OP_SUB, 2, 1, 1'b0);
        repeat (5) @(posedge clk);
        if (complete_count != equals_count) begin
            fail_count++;
            $display("saw %0d complete pulses for %0d equals keys",
                     complete_count, equals_count);
        end
        end_test("completion pulse", errors_before);

        $display("checks passed %0d, failed %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* files.f */
+incdir+verification
design/calc_pkg.sv
design/add_sub_unit.sv
design/mult_unit.sv
design/calc_ctrl.sv
design/calc_top.sv
verification/calc_tb.sv

/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal
TOP       := calc_tb
FILELIST  := files.f
OBJ_DIR   := obj_dir
PASS_MSG  := TESTS PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
